/* design/mul_settings.svh */
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

`define MUL_WIDTH        32
`define APB_AW           8

`define REG_OP_A         8'h00
`define REG_OP_B         8'h04
`define REG_CTRL         8'h08
`define REG_STATUS       8'h0C
`define REG_RES_LO       8'h10
`define REG_RES_HI       8'h14

`define CTRL_START_BIT   0
`define CTRL_SIGNED_BIT  1
`define STAT_BUSY_BIT    0
`define STAT_DONE_BIT    1

`endif

/* design/mul_pkg.sv */
`include "mul_settings.svh"

package mul_pkg;

    // one operand, also one apb data word
    typedef logic [`MUL_WIDTH-1:0] operand_t;

    // full product or unsigned magnitude product
    typedef logic [2*`MUL_WIDTH-1:0] product_t;

    typedef logic [`APB_AW-1:0] apb_addr_t;

    // counts run cycles, one per multiplier bit
    typedef logic [5:0] iter_cnt_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_RUN,
        ST_FINISH
    } mul_state_e;

endpackage

/* design/mul_apb_decode.sv */
`timescale 1ns/10ps
`include "mul_settings.svh"

module mul_apb_decode
    import mul_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  operand_t  pwdata,
    input  logic      busy,
    input  operand_t  res_lo,
    input  operand_t  res_hi,
    input  logic      done,
    output operand_t  prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      start,
    output logic      signed_mode,
    output operand_t  op_a,
    output operand_t  op_b
);

    logic access;
    logic addr_hit;
    logic engaged;
    logic start_req;
    logic start_reject;
    logic wr_ok;

    assign access = psel & penable;             // apb access phase
    assign engaged = busy | start;              // job running or start pulse pending

    always_comb
    begin
        case (paddr)
            `REG_OP_A, `REG_OP_B, `REG_CTRL,
            `REG_STATUS, `REG_RES_LO, `REG_RES_HI: addr_hit = 1'b1;
            default:                               addr_hit = 1'b0;
        endcase
    end

    assign start_req = access & pwrite & (paddr == `REG_CTRL) & pwdata[`CTRL_START_BIT];
    assign start_reject = start_req & engaged;  // second job not queued
    assign wr_ok = access & pwrite & ~engaged;  // config frozen while a job runs

    assign pready = 1'b1;                       // no wait states
    assign pslverr = access & (~addr_hit | start_reject);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            op_a        <= '0;
            op_b        <= '0;
            signed_mode <= 1'b0;
        end
        else if (wr_ok)
        begin
            case (paddr)
                `REG_OP_A: op_a <= pwdata;
                `REG_OP_B: op_b <= pwdata;
                `REG_CTRL: signed_mode <= pwdata[`CTRL_SIGNED_BIT];
                default:   ;                    // status and result are read only
            endcase
        end
    end

    // one cycle pulse after the accepted ctrl write
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            start <= 1'b0;
        else
            start <= start_req & ~engaged;
    end

    always_comb
    begin
        prdata = '0;
        if (access && !pwrite)
        begin
            case (paddr)
                `REG_OP_A:   prdata = op_a;
                `REG_OP_B:   prdata = op_b;
                `REG_CTRL:   prdata[`CTRL_SIGNED_BIT] = signed_mode;
                `REG_STATUS:
                begin
                    prdata[`STAT_BUSY_BIT] = engaged;
                    prdata[`STAT_DONE_BIT] = done;
                end
                `REG_RES_LO: prdata = res_lo;
                `REG_RES_HI: prdata = res_hi;
                default:     prdata = '0;
            endcase
        end
    end

endmodule

/* design/mul_shift_add.sv */
`timescale 1ns/10ps
`include "mul_settings.svh"

module mul_shift_add
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  logic     signed_mode,
    input  operand_t op_a,
    input  operand_t op_b,
    output logic     busy,
    output logic     finish,
    output product_t mag_product,
    output logic     negate
);

    localparam iter_cnt_t ITER_LAST = iter_cnt_t'(`MUL_WIDTH - 1);

    mul_state_e state;
    mul_state_e state_nxt;

    product_t   multiplicand;                   // shifts left each run cycle
    operand_t   multiplier;                     // shifts right each run cycle
    operand_t   multiplier_shr;
    product_t   acc;
    iter_cnt_t  iter_cnt;

    logic       sign_a;
    logic       sign_b;
    operand_t   mag_a;
    operand_t   mag_b;
    logic       run_done;

    // sign bits only count in signed mode
    assign sign_a = signed_mode & op_a[`MUL_WIDTH-1];
    assign sign_b = signed_mode & op_b[`MUL_WIDTH-1];
    assign mag_a = sign_a ? (~op_a + 1'b1) : op_a;
    assign mag_b = sign_b ? (~op_b + 1'b1) : op_b;

    assign multiplier_shr = multiplier >> 1;

    // early exit once no set bits remain
    assign run_done = (multiplier_shr == '0) || (iter_cnt == ITER_LAST);

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
            begin
                if (start)
                    state_nxt = ST_LOAD;
            end
            ST_LOAD:   state_nxt = ST_RUN;
            ST_RUN:
            begin
                if (run_done)
                    state_nxt = ST_FINISH;
            end
            ST_FINISH: state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            iter_cnt <= '0;
            negate   <= 1'b0;
        end
        else if (state == ST_LOAD)
        begin
            iter_cnt <= '0;
            negate   <= sign_a ^ sign_b;
        end
        else if (state == ST_RUN)
        begin
            iter_cnt <= iter_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            ST_LOAD:
            begin
                multiplicand <= {{`MUL_WIDTH{1'b0}}, mag_a};
                multiplier   <= mag_b;
                acc          <= '0;
            end
            ST_RUN:
            begin
                if (multiplier[0])
                    acc <= acc + multiplicand;  // partial product for this bit
                multiplicand <= multiplicand << 1;
                multiplier   <= multiplier_shr;
            end
            default: ;
        endcase
    end

    assign busy        = (state != ST_IDLE);
    assign finish      = (state == ST_FINISH);
    assign mag_product = acc;                   // settled by the finish cycle

endmodule

/* design/mul_result.sv */
`timescale 1ns/10ps
`include "mul_settings.svh"

module mul_result
    import mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  logic     finish,
    input  product_t mag_product,
    input  logic     negate,
    output operand_t res_lo,
    output operand_t res_hi,
    output logic     done
);

    product_t fixed_product;

    // a zero magnitude stays zero after negation
    assign fixed_product = negate ? (~mag_product + 1'b1) : mag_product;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            res_lo <= '0;
            res_hi <= '0;
        end
        else if (finish)
        begin
            res_lo <= fixed_product[`MUL_WIDTH-1:0];
            res_hi <= fixed_product[2*`MUL_WIDTH-1:`MUL_WIDTH];
        end
    end

    // sticky until the host starts another job
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            done <= 1'b0;
        else if (finish)
            done <= 1'b1;
        else if (start)
            done <= 1'b0;
    end

endmodule

/* design/mul_apb_top.sv */
`timescale 1ns/10ps

module mul_apb_top
    import mul_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  operand_t  pwdata,
    output operand_t  prdata,
    output logic      pready,
    output logic      pslverr
);

    logic     start;
    logic     signed_mode;
    operand_t op_a;
    operand_t op_b;
    logic     busy;
    logic     finish;
    product_t mag_product;
    logic     negate;
    operand_t res_lo;
    operand_t res_hi;
    logic     done;

    mul_apb_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .busy        (busy),
        .res_lo      (res_lo),
        .res_hi      (res_hi),
        .done        (done),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .start       (start),
        .signed_mode (signed_mode),
        .op_a        (op_a),
        .op_b        (op_b)
    );

    mul_shift_add u_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .signed_mode (signed_mode),
        .op_a        (op_a),
        .op_b        (op_b),
        .busy        (busy),
        .finish      (finish),
        .mag_product (mag_product),
        .negate      (negate)
    );

    mul_result u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .finish      (finish),
        .mag_product (mag_product),
        .negate      (negate),
        .res_lo      (res_lo),
        .res_hi      (res_hi),
        .done        (done)
    );

endmodule

/* bench/mul_checker.sv */
`timescale 1ns/10ps
`include "mul_settings.svh"

module mul_checker
    import mul_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  operand_t  pwdata,
    input  operand_t  prdata,
    input  logic      pready,
    input  logic      pslverr,
    output int        total_errors,
    output int        total_checks,
    output int        failed_tests
);

    operand_t m_op_a;
    operand_t m_op_b;
    logic     m_signed;
    product_t m_product;
    logic     m_pending;                        // started, done not yet seen in status
    logic     exp_err;
    int       test_errors;
    int       test_checks;

    function automatic product_t ref_product(input operand_t a, input operand_t b,
                                             input logic sgn);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        sa = $signed(a);                        // sign extended to 64 bits
        sb = $signed(b);
        ua = a;
        ub = b;
        if (sgn)
            return product_t'(sa * sb);
        return ua * ub;
    endfunction

    function automatic logic is_mapped(input apb_addr_t addr);
        return addr == `REG_OP_A || addr == `REG_OP_B || addr == `REG_CTRL ||
               addr == `REG_STATUS || addr == `REG_RES_LO || addr == `REG_RES_HI;
    endfunction

    task automatic check_value(input string what, input operand_t got, input operand_t exp);
        test_checks++;
        total_checks++;
        if (got !== exp)
        begin
            test_errors++;
            total_errors++;
            $display("ERR t=%0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // failures found by the stimulus side, e.g. a job that never completes
    task automatic note_error(input string msg);
        test_errors++;
        total_errors++;
        $display("t=%0t: %s", $time, msg);
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0)
            $display("test %-18s checks %5d  errors %0d  ok", name, test_checks, test_errors);
        else
        begin
            $display("test %-18s checks %5d  errors %0d  FAILED", name, test_checks,
                     test_errors);
            failed_tests++;
        end
        test_errors = 0;
        test_checks = 0;
    endtask

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            m_op_a    = '0;
            m_op_b    = '0;
            m_signed  = 1'b0;
            m_product = '0;
            m_pending = 1'b0;
        end
        else if (psel && penable && pready)
        begin
            exp_err = !is_mapped(paddr) ||
                      (pwrite && paddr == `REG_CTRL && pwdata[`CTRL_START_BIT] && m_pending);
            check_value("pslverr", operand_t'(pslverr), operand_t'(exp_err));
            if (pwrite && !m_pending)
            begin
                case (paddr)
                    `REG_OP_A: m_op_a = pwdata;
                    `REG_OP_B: m_op_b = pwdata;
                    `REG_CTRL:
                    begin
                        m_signed = pwdata[`CTRL_SIGNED_BIT];
                        if (pwdata[`CTRL_START_BIT])
                        begin
                            m_product = ref_product(m_op_a, m_op_b, m_signed);
                            m_pending = 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            else if (!pwrite)
            begin
                case (paddr)
                    `REG_OP_A:   check_value("op_a", prdata, m_op_a);
                    `REG_OP_B:   check_value("op_b", prdata, m_op_b);
                    `REG_CTRL:   check_value("ctrl", prdata, operand_t'(m_signed) << 1);
                    `REG_STATUS:
                    begin
                        check_value("status upper bits", prdata & ~operand_t'(3), '0);
                        check_value("status done with busy", operand_t'(prdata[1] & prdata[0]),
                                    '0);
                        if (prdata[`STAT_DONE_BIT])
                            m_pending = 1'b0;
                    end
                    `REG_RES_LO: check_value("res_lo", prdata, m_product[31:0]);
                    `REG_RES_HI: check_value("res_hi", prdata, m_product[63:32]);
                    default:     check_value("unmapped read data", prdata, '0);
                endcase
            end
        end
    end

endmodule

/* bench/mul_asserts.sv */
`timescale 1ns/10ps

module mul_asserts
    import mul_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic start,
    input logic busy
);

    int fail_count;                             // read by the testbench at the end

    pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else begin fail_count++; $error("pready went low"); end

    err_in_access: assert property (@(posedge clk) disable iff (!rst_n)
                                    pslverr |-> (psel && penable))
        else begin fail_count++; $error("pslverr outside an access phase"); end

    busy_after_start: assert property (@(posedge clk) disable iff (!rst_n) start |=> busy)
        else begin fail_count++; $error("busy did not rise after start"); end

    // load, up to 32 run cycles, finish
    busy_bounded: assert property (@(posedge clk) disable iff (!rst_n)
                                   $rose(busy) |-> ##[1:36] !busy)
        else begin fail_count++; $error("busy held longer than 36 cycles"); end

    no_start_busy: assert property (@(posedge clk) disable iff (!rst_n) !(start && busy))
        else begin fail_count++; $error("start pulse while busy"); end

endmodule

bind mul_apb_top mul_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .start   (start),
    .busy    (busy)
);

/* bench/mul_tb.sv */
`timescale 1ns/10ps
`include "mul_settings.svh"

module mul_tb
    import mul_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int N_TESTS    = 6;
    localparam int MAX_JOBS   = 50;             // corner test is the longest
    localparam int RAND_JOBS  = 24;
    localparam int POLL_LIMIT = 40;
    // register traffic and polling roughly double the raw job time
    localparam int WATCHDOG_NS = N_TESTS * MAX_JOBS * 40 * CLK_PERIOD * 2 + 2000;
    localparam operand_t CORNERS [5] = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000,
                                          32'h7FFF_FFFF};

    logic      clk;
    logic      rst_n;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    operand_t  pwdata;
    operand_t  prdata;
    logic      pready;
    logic      pslverr;
    int        total_errors;
    int        total_checks;
    int        failed_tests;
    int        tests_run;
    operand_t  a;
    operand_t  b;
    operand_t  rd;
    apb_addr_t bad_addr;

    mul_apb_top u_mul_apb_top (.clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel),
        .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr));

    mul_checker u_checker (.clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel),
        .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .total_errors(total_errors),
        .total_checks(total_checks), .failed_tests(failed_tests));

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired: the run timed out before all tests finished");
        $display("Some tests failed");
        $finish;
    end

    task automatic apb_xfer(input apb_addr_t addr, input logic wr, input operand_t wdata,
                            output operand_t rdata);
        @(posedge clk);
        paddr   <= addr;                        // setup phase
        pwrite  <= wr;
        pwdata  <= wr ? wdata : '0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        do
            @(posedge clk);
        while (!pready);
        rdata = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input operand_t data);
        operand_t unused;
        apb_xfer(addr, 1'b1, data, unused);
    endtask

    task automatic wait_done();
        operand_t status;
        int       polls;
        status = '0;
        polls = 0;
        while (!status[`STAT_DONE_BIT] && polls < POLL_LIMIT)
        begin
            apb_xfer(`REG_STATUS, 1'b0, '0, status);
            polls++;
        end
        if (!status[`STAT_DONE_BIT])
            u_checker.note_error("job never reported done within the poll limit");
    endtask

    function automatic operand_t ctrl_word(input logic sgn);
        operand_t w;
        w = '0;
        w[`CTRL_START_BIT] = 1'b1;
        w[`CTRL_SIGNED_BIT] = sgn;
        return w;
    endfunction

    // optional second start lands while the first job is still running
    task automatic run_job(input operand_t op1, input operand_t op2, input logic sgn,
                           input logic restart);
        operand_t r;
        apb_write(`REG_OP_A, op1);
        apb_write(`REG_OP_B, op2);
        apb_write(`REG_CTRL, ctrl_word(sgn));
        if (restart)
            apb_write(`REG_CTRL, ctrl_word(~sgn));
        wait_done();
        apb_xfer(`REG_RES_LO, 1'b0, '0, r);
        apb_xfer(`REG_RES_HI, 1'b0, '0, r);
        apb_xfer(`REG_CTRL, 1'b0, '0, r);      // mode bit of the job that ran
    endtask

    task automatic finish_test(input string name);
        u_checker.report_test(name);
        tests_run++;
    endtask

    initial
    begin
        rst_n = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        tests_run = 0;
        void'($urandom(71));
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < RAND_JOBS; i++)
        begin
            apb_write(`REG_OP_A, $urandom);
            apb_write(`REG_OP_B, $urandom);
            apb_xfer(`REG_OP_A, 1'b0, '0, rd);
            apb_xfer(`REG_OP_B, 1'b0, '0, rd);
        end
        finish_test("operand_readback");

        for (int mode = 1; mode >= 0; mode--)
        begin
            for (int i = 0; i < RAND_JOBS; i++)
            begin
                a = $urandom;
                b = $urandom >> $urandom_range(0, 31);  // short and long runs
                a[31] = i[0];                   // every sign combination
                b[31] = i[1];
                run_job(a, b, mode[0], 1'b0);
            end
            finish_test(mode ? "signed_random" : "unsigned_random");
        end

        for (int i = 0; i < 5; i++)
            for (int j = 0; j < 5; j++)
                for (int mode = 0; mode < 2; mode++)
                    run_job(CORNERS[i], CORNERS[j], mode[0], 1'b0);
        finish_test("corner_operands");

        for (int i = 0; i < 8; i++)
            run_job($urandom, $urandom, i[0], 1'b1);
        finish_test("start_while_busy");

        for (int i = 0; i < RAND_JOBS; i++)
        begin
            bad_addr = i[0] ? apb_addr_t'(8'h18 + $urandom_range(0, 8'hE7)) :
                              apb_addr_t'($urandom_range(0, 8'h17) | 1);
            apb_write(bad_addr, $urandom);
            apb_xfer(bad_addr, 1'b0, '0, rd);
            apb_xfer(`REG_OP_A, 1'b0, '0, rd);
            apb_xfer(`REG_OP_B, 1'b0, '0, rd);
        end
        finish_test("unmapped_address");

        $display("summary: %0d tests, %0d failing, %0d checks, %0d errors, %0d assertion fails",
                 tests_run, failed_tests, total_checks, total_errors,
                 u_mul_apb_top.u_asserts.fail_count);
        if (failed_tests == 0 && total_errors == 0 && u_mul_apb_top.u_asserts.fail_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+design
design/mul_pkg.sv
design/mul_apb_decode.sv
design/mul_shift_add.sv
design/mul_result.sv
design/mul_apb_top.sv
bench/mul_checker.sv
bench/mul_asserts.sv
bench/mul_tb.sv
